// ==== build.f ====
logic/xbar_pkg.sv
logic/xbar_fifo.sv
logic/xbar_rr_arbiter.sv
logic/xbar_master_side.sv
logic/xbar_slave_side.sv
logic/xbar.sv
sim/xbar_slave_model.sv
sim/xbar_chk.sv
sim/xbar_tb.sv

// ==== logic/xbar.sv ====
`timescale 1ns/1ps

module xbar (
	input logic clk,
	input logic rst_n,

	// Outer masters
	input xbar_pkg::ar_t ar_m [xbar_pkg::num_masters],
	input logic [xbar_pkg::num_masters-1:0] ar_valid_m,
	output logic [xbar_pkg::num_masters-1:0] ar_ready_m,
	output xbar_pkg::r_t r_m [xbar_pkg::num_masters],
	output logic [xbar_pkg::num_masters-1:0] r_valid_m,
	input logic [xbar_pkg::num_masters-1:0] r_ready_m,

	// Outer slaves
	output xbar_pkg::ars_t ar_s [xbar_pkg::num_slaves],
	output logic [xbar_pkg::num_slaves-1:0] ar_valid_s,
	input logic [xbar_pkg::num_slaves-1:0] ar_ready_s,
	input xbar_pkg::rs_t r_s [xbar_pkg::num_slaves],
	input logic [xbar_pkg::num_slaves-1:0] r_valid_s,
	output logic [xbar_pkg::num_slaves-1:0] r_ready_s
);

	// Request bus driven per master
	xbar_pkg::ar_t req [xbar_pkg::num_masters];
	logic [xbar_pkg::num_masters-1:0] req_valid;
	logic [xbar_pkg::slave_idx_w-1:0] req_dest [xbar_pkg::num_masters];
	logic [xbar_pkg::num_masters-1:0] req_taken;
	logic [xbar_pkg::num_masters-1:0] req_valid_to [xbar_pkg::num_slaves];
	logic [xbar_pkg::num_masters-1:0] req_grant [xbar_pkg::num_slaves];

	// Return bus driven per slave
	xbar_pkg::r_t ret [xbar_pkg::num_slaves];
	logic [xbar_pkg::num_slaves-1:0] ret_valid;
	logic [xbar_pkg::master_idx_w-1:0] ret_dest [xbar_pkg::num_slaves];
	logic [xbar_pkg::num_slaves-1:0] ret_taken;
	logic [xbar_pkg::num_slaves-1:0] ret_valid_to [xbar_pkg::num_masters];
	logic [xbar_pkg::num_slaves-1:0] ret_grant [xbar_pkg::num_masters];

	for (genvar m = 0; m < xbar_pkg::num_masters; m++) begin : g_master
		xbar_master_side i_master_side (
			.clk(clk),
			.rst_n(rst_n),
			.ar_m(ar_m[m]),
			.ar_valid_m(ar_valid_m[m]),
			.ar_ready_m(ar_ready_m[m]),
			.r_m(r_m[m]),
			.r_valid_m(r_valid_m[m]),
			.r_ready_m(r_ready_m[m]),
			.req(req[m]),
			.req_valid(req_valid[m]),
			.req_dest(req_dest[m]),
			.req_taken(req_taken[m]),
			.ret_in(ret),
			.ret_valid_in(ret_valid_to[m]),
			.ret_grant(ret_grant[m])
		);
	end

	for (genvar s = 0; s < xbar_pkg::num_slaves; s++) begin : g_slave
		xbar_slave_side #(
			.my_index(s)
		) i_slave_side (
			.clk(clk),
			.rst_n(rst_n),
			.req_in(req),
			.req_valid_in(req_valid_to[s]),
			.req_grant(req_grant[s]),
			.ar_s(ar_s[s]),
			.ar_valid_s(ar_valid_s[s]),
			.ar_ready_s(ar_ready_s[s]),
			.r_s(r_s[s]),
			.r_valid_s(r_valid_s[s]),
			.r_ready_s(r_ready_s[s]),
			.ret(ret[s]),
			.ret_valid(ret_valid[s]),
			.ret_dest(ret_dest[s]),
			.ret_taken(ret_taken[s])
		);
	end

	// Forward valids go out by destination and grants come back to the masters
	always_comb begin
		req_taken = '0;
		for (int s = 0; s < xbar_pkg::num_slaves; s++)
			for (int m = 0; m < xbar_pkg::num_masters; m++) begin
				req_valid_to[s][m] = req_valid[m] && (req_dest[m] == xbar_pkg::slave_idx_w'(s));
				req_taken[m] = req_taken[m] | req_grant[s][m];
			end
	end

	// Return path uses the same scheme in the other direction
	always_comb begin
		ret_taken = '0;
		for (int m = 0; m < xbar_pkg::num_masters; m++)
			for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
				ret_valid_to[m][s] = ret_valid[s] && (ret_dest[s] == xbar_pkg::master_idx_w'(m));
				ret_taken[s] = ret_taken[s] | ret_grant[m][s];
			end
	end

endmodule

// ==== logic/xbar_fifo.sv ====
`timescale 1ns/1ps

module xbar_fifo #(
	parameter type payload_t = logic,
	parameter int depth = 8
) (
	input logic clk,
	input logic rst_n,
	input logic push,
	input payload_t push_data,
	output logic full,
	input logic pop,
	output payload_t pop_data,
	output logic empty
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0] count;
	logic do_push;
	logic do_pop;

	assign full = (count == (ptr_w + 1)'(depth));
	assign empty = (count == '0);
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	// Head entry is visible without a pop
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// ==== logic/xbar_master_side.sv ====
`timescale 1ns/1ps

module xbar_master_side (
	input logic clk,
	input logic rst_n,

	// Outer master
	input xbar_pkg::ar_t ar_m,
	input logic ar_valid_m,
	output logic ar_ready_m,
	output xbar_pkg::r_t r_m,
	output logic r_valid_m,
	input logic r_ready_m,

	// Request bus
	output xbar_pkg::ar_t req,
	output logic req_valid,
	output logic [xbar_pkg::slave_idx_w-1:0] req_dest,
	input logic req_taken,

	// Return bus
	input xbar_pkg::r_t ret_in [xbar_pkg::num_slaves],
	input logic [xbar_pkg::num_slaves-1:0] ret_valid_in,
	output logic [xbar_pkg::num_slaves-1:0] ret_grant
);

	// Queued request with its decoded target
	typedef struct packed {
		logic [xbar_pkg::slave_idx_w-1:0] dest;
		xbar_pkg::ar_t ar;
	} req_entry_t;

	req_entry_t in_entry;
	req_entry_t out_entry;
	logic req_full;
	logic req_empty;

	logic [xbar_pkg::num_slaves-1:0] arb_grant;
	logic can_take;
	logic beat_take;
	logic in_burst;
	xbar_pkg::r_t sel_beat;

	// Address decode with slave 0 as the default
	always_comb begin
		in_entry.ar = ar_m;
		in_entry.dest = '0;
		for (int s = 0; s < xbar_pkg::num_slaves; s++)
			if (ar_m.addr >= xbar_pkg::map_base[s] && ar_m.addr <= xbar_pkg::map_end[s])
				in_entry.dest = xbar_pkg::slave_idx_w'(s);
	end

	xbar_fifo #(
		.payload_t(req_entry_t),
		.depth(xbar_pkg::pending_depth)
	) i_req_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(ar_valid_m),
		.push_data(in_entry),
		.full(req_full),
		.pop(req_taken),
		.pop_data(out_entry),
		.empty(req_empty)
	);

	assign ar_ready_m = !req_full;
	assign req = out_entry.ar;
	assign req_dest = out_entry.dest;
	assign req_valid = !req_empty;

	// Return grant stays locked to one slave until last
	xbar_rr_arbiter #(
		.n(xbar_pkg::num_slaves)
	) i_ret_arb (
		.clk(clk),
		.rst_n(rst_n),
		.req(ret_valid_in),
		.hold(in_burst),
		.advance(beat_take && sel_beat.last),
		.grant(arb_grant)
	);

	// Output register free or draining this cycle
	assign can_take = !r_valid_m || r_ready_m;
	assign ret_grant = arb_grant & ret_valid_in & {xbar_pkg::num_slaves{can_take}};
	assign beat_take = |ret_grant;

	always_comb begin
		sel_beat = ret_in[0];
		for (int s = 0; s < xbar_pkg::num_slaves; s++)
			if (ret_grant[s])
				sel_beat = ret_in[s];
	end

	always_ff @(posedge clk) begin
		if (beat_take)
			r_m <= sel_beat;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			r_valid_m <= 1'b0;
			in_burst <= 1'b0;
		end else begin
			if (beat_take)
				r_valid_m <= 1'b1;
			else if (r_ready_m)
				r_valid_m <= 1'b0;
			if (beat_take)
				in_burst <= !sel_beat.last;
		end
	end

endmodule

// ==== logic/xbar_pkg.sv ====
package xbar_pkg;

	// Port counts and the index widths that select them
	localparam int num_masters = 2;
	localparam int num_slaves = 2;
	localparam int master_idx_w = 1;
	localparam int slave_idx_w = 1;

	// Slave-side IDs carry the master index above the original ID
	localparam int id_w = 4;
	localparam int ids_w = id_w + master_idx_w;

	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int len_w = 4;
	localparam int size_w = 3;

	localparam int pending_depth = 8;

	// Anything outside both address windows lands on slave 0
	localparam logic [addr_w-1:0] map_base [num_slaves] = '{32'h0000_0000, 32'h1000_0000};
	localparam logic [addr_w-1:0] map_end [num_slaves] = '{32'h0fff_ffff, 32'h1fff_ffff};

	localparam logic [1:0] resp_okay = 2'b00;

	// Read request on the master side
	typedef struct packed {
		logic [id_w-1:0] id;
		logic [addr_w-1:0] addr;
		logic [len_w-1:0] len;
		logic [size_w-1:0] size;
		logic [1:0] burst;
	} ar_t;

	// Read request on the slave side
	typedef struct packed {
		logic [ids_w-1:0] id;
		logic [addr_w-1:0] addr;
		logic [len_w-1:0] len;
		logic [size_w-1:0] size;
		logic [1:0] burst;
	} ars_t;

	// Read beat on the master side
	typedef struct packed {
		logic [id_w-1:0] id;
		logic [data_w-1:0] data;
		logic [1:0] resp;
		logic last;
	} r_t;

	// Read beat on the slave side
	typedef struct packed {
		logic [ids_w-1:0] id;
		logic [data_w-1:0] data;
		logic [1:0] resp;
		logic last;
	} rs_t;

endpackage

// ==== logic/xbar_rr_arbiter.sv ====
`timescale 1ns/1ps

module xbar_rr_arbiter #(
	parameter int n = 2
) (
	input logic clk,
	input logic rst_n,
	input logic [n-1:0] req,
	input logic hold,
	input logic advance,
	output logic [n-1:0] grant
);

	localparam int idx_w = (n > 1) ? $clog2(n) : 1;

	logic [idx_w-1:0] last_idx;
	logic [idx_w-1:0] grant_idx;
	logic [n-1:0] pick;
	logic [n-1:0] held;

	// First requester after the last winner
	always_comb begin
		int k;
		pick = '0;
		for (int i = 1; i <= n; i++) begin
			k = (int'(last_idx) + i) % n;
			if (pick == '0 && req[k])
				pick[k] = 1'b1;
		end
	end

	assign grant = hold ? held : pick;

	always_comb begin
		grant_idx = '0;
		for (int i = 0; i < n; i++)
			if (grant[i])
				grant_idx = idx_w'(i);
	end

	// Reset pointer on the top requester so index 0 wins first
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_idx <= idx_w'(n - 1);
			held <= '0;
		end else begin
			if (!hold)
				held <= pick;
			if (advance)
				last_idx <= grant_idx;
		end
	end

endmodule

// ==== logic/xbar_slave_side.sv ====
`timescale 1ns/1ps

module xbar_slave_side #(
	parameter int my_index = 0
) (
	input logic clk,
	input logic rst_n,

	// Request bus
	input xbar_pkg::ar_t req_in [xbar_pkg::num_masters],
	input logic [xbar_pkg::num_masters-1:0] req_valid_in,
	output logic [xbar_pkg::num_masters-1:0] req_grant,

	// Outer slave
	output xbar_pkg::ars_t ar_s,
	output logic ar_valid_s,
	input logic ar_ready_s,
	input xbar_pkg::rs_t r_s,
	input logic r_valid_s,
	output logic r_ready_s,

	// Return bus
	output xbar_pkg::r_t ret,
	output logic ret_valid,
	output logic [xbar_pkg::master_idx_w-1:0] ret_dest,
	input logic ret_taken
);

	logic [xbar_pkg::num_masters-1:0] arb_req;
	logic [xbar_pkg::num_masters-1:0] arb_grant;
	logic can_take;
	logic take;
	xbar_pkg::ar_t sel_req;
	logic [xbar_pkg::master_idx_w-1:0] sel_idx;

	xbar_pkg::rs_t head;
	logic ret_full;
	logic ret_empty;

	// Stagger the starting priority across slave ports
	always_comb begin
		for (int m = 0; m < xbar_pkg::num_masters; m++)
			arb_req[m] = req_valid_in[(m + my_index) % xbar_pkg::num_masters];
	end

	xbar_rr_arbiter #(
		.n(xbar_pkg::num_masters)
	) i_req_arb (
		.clk(clk),
		.rst_n(rst_n),
		.req(arb_req),
		.hold(1'b0),
		.advance(take),
		.grant(arb_grant)
	);

	assign can_take = !ar_valid_s || ar_ready_s;

	always_comb begin
		req_grant = '0;
		for (int m = 0; m < xbar_pkg::num_masters; m++)
			req_grant[(m + my_index) % xbar_pkg::num_masters] = arb_grant[m] && can_take;
	end

	assign take = |req_grant;

	always_comb begin
		sel_req = req_in[0];
		sel_idx = '0;
		for (int m = 0; m < xbar_pkg::num_masters; m++)
			if (req_grant[m]) begin
				sel_req = req_in[m];
				sel_idx = xbar_pkg::master_idx_w'(m);
			end
	end

	// Master index goes in front of the original ID
	always_ff @(posedge clk) begin
		if (take) begin
			ar_s.id <= {sel_idx, sel_req.id};
			ar_s.addr <= sel_req.addr;
			ar_s.len <= sel_req.len;
			ar_s.size <= sel_req.size;
			ar_s.burst <= sel_req.burst;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ar_valid_s <= 1'b0;
		else if (take)
			ar_valid_s <= 1'b1;
		else if (ar_ready_s)
			ar_valid_s <= 1'b0;
	end

	xbar_fifo #(
		.payload_t(xbar_pkg::rs_t),
		.depth(xbar_pkg::pending_depth)
	) i_ret_fifo (
		.clk(clk),
		.rst_n(rst_n),
		.push(r_valid_s),
		.push_data(r_s),
		.full(ret_full),
		.pop(ret_taken),
		.pop_data(head),
		.empty(ret_empty)
	);

	assign r_ready_s = !ret_full;
	assign ret_valid = !ret_empty;

	// Top ID bits pick the master and the rest is the original ID
	assign ret_dest = head.id[xbar_pkg::ids_w-1 -: xbar_pkg::master_idx_w];
	assign ret.id = head.id[xbar_pkg::id_w-1:0];
	assign ret.data = head.data;
	assign ret.resp = head.resp;
	assign ret.last = head.last;

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module xbar_tb -f build.f -o xbar_sim \
	&& ./obj_dir/xbar_sim | tee /dev/stderr | grep "Testbench passed" > /dev/null \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

// ==== sim/xbar_chk.sv ====
`timescale 1ns/1ps

module xbar_chk (
	input logic clk,
	input logic rst_n,
	input xbar_pkg::ars_t ar_s [xbar_pkg::num_slaves],
	input logic [xbar_pkg::num_slaves-1:0] ar_valid_s,
	input logic [xbar_pkg::num_slaves-1:0] ar_ready_s,
	input xbar_pkg::r_t r_m [xbar_pkg::num_masters],
	input logic [xbar_pkg::num_masters-1:0] r_valid_m,
	input logic [xbar_pkg::num_masters-1:0] r_ready_m,
	input logic [xbar_pkg::num_masters-1:0] req_grant [xbar_pkg::num_slaves]
);

	for (genvar s = 0; s < xbar_pkg::num_slaves; s++) begin : g_slave
		// Stalled request keeps valid and payload
		a_ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
			ar_valid_s[s] && !ar_ready_s[s] |=> ar_valid_s[s] && $stable(ar_s[s]))
			else $error("ar_s[%0d] changed before it was accepted", s);

		// At most one master wins a slave port per cycle
		a_grant_onehot: assert property (@(posedge clk) $onehot0(req_grant[s]))
			else $error("req_grant of slave port %0d has more than one bit set", s);
	end

	for (genvar m = 0; m < xbar_pkg::num_masters; m++) begin : g_master
		a_r_stable: assert property (@(posedge clk) disable iff (!rst_n)
			r_valid_m[m] && !r_ready_m[m] |=> r_valid_m[m] && $stable(r_m[m]))
			else $error("r_m[%0d] changed before it was accepted", m);
	end

	a_r_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> r_valid_m == '0)
		else $error("r_valid_m was high during reset");

endmodule

// ==== sim/xbar_slave_model.sv ====
`timescale 1ns/1ps

module xbar_slave_model (
	input logic clk,
	input logic rst_n,
	input xbar_pkg::ars_t ar,
	input logic ar_valid,
	output logic ar_ready,
	input logic accept,
	output xbar_pkg::rs_t r,
	output logic r_valid,
	input logic r_ready
);

	// Accepted requests are served strictly in order
	xbar_pkg::ars_t pending [$];
	int beat;

	// Ready pattern comes from the testbench
	assign ar_ready = accept;

	function automatic xbar_pkg::rs_t beat_for(input xbar_pkg::ars_t a, input int k);
		xbar_pkg::rs_t b;
		b.id = a.id;
		b.data = ~(a.addr + xbar_pkg::addr_w'(4 * k));
		b.resp = xbar_pkg::resp_okay;
		b.last = (k == int'(a.len));
		return b;
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pending.delete();
			beat = 0;
			r <= '0;
			r_valid <= 1'b0;
		end else begin
			if (r_valid && r_ready) begin
				if (r.last) begin
					void'(pending.pop_front());
					beat = 0;
				end else
					beat = beat + 1;
			end
			if (ar_valid && ar_ready)
				pending.push_back(ar);
			// Next beat only once the current one is taken
			if (!r_valid || r_ready) begin
				if (pending.size() > 0) begin
					r <= beat_for(pending[0], beat);
					r_valid <= 1'b1;
				end else
					r_valid <= 1'b0;
			end
		end
	end

endmodule

// ==== sim/xbar_tb.sv ====
`timescale 1ns/1ps

module xbar_tb;

	typedef struct packed {
		logic [xbar_pkg::master_idx_w-1:0] master;
		logic [xbar_pkg::id_w-1:0] id;
		logic [xbar_pkg::addr_w-1:0] addr;
		logic [xbar_pkg::len_w-1:0] len;
		logic [xbar_pkg::slave_idx_w-1:0] slave;
	} row_t;

	localparam int num_rows = 14;
	localparam int timeout_cycles = num_rows * 16 * 8;
	localparam logic [xbar_pkg::size_w-1:0] beat_size = 3'd2;
	localparam logic [1:0] burst_incr = 2'b01;

	// Master, ID, address, length, expected slave
	// Each master issues its own rows in table order, so pairs line up in time
	localparam row_t stim [num_rows] = '{
		'{1'b0, 4'h1, 32'h0000_0100, 4'd0, 1'b0},
		'{1'b1, 4'h1, 32'h1800_0000, 4'd0, 1'b1},
		'{1'b0, 4'h2, 32'h1000_0200, 4'd1, 1'b1},
		'{1'b1, 4'h2, 32'h4000_0000, 4'd2, 1'b0},
		'{1'b0, 4'h3, 32'hf000_0010, 4'd0, 1'b0},
		'{1'b1, 4'h3, 32'h2000_0000, 4'd1, 1'b0},
		// Both masters on slave 0
		'{1'b0, 4'h4, 32'h0000_1000, 4'd3, 1'b0},
		'{1'b1, 4'h4, 32'h0200_0000, 4'd3, 1'b0},
		// Long bursts from both slaves into each master
		'{1'b0, 4'h5, 32'h0000_2000, 4'd7, 1'b0},
		'{1'b1, 4'h5, 32'h1000_4000, 4'd15, 1'b1},
		'{1'b0, 4'h6, 32'h1000_3000, 4'd7, 1'b1},
		'{1'b1, 4'h6, 32'h0800_0000, 4'd5, 1'b0},
		'{1'b0, 4'h7, 32'h1fff_fff0, 4'd2, 1'b1},
		'{1'b1, 4'h7, 32'h0fff_fffc, 4'd0, 1'b0}
	};

	logic clk;
	logic rst_n;
	xbar_pkg::ar_t ar_m [xbar_pkg::num_masters];
	logic [xbar_pkg::num_masters-1:0] ar_valid_m;
	logic [xbar_pkg::num_masters-1:0] ar_ready_m;
	xbar_pkg::r_t r_m [xbar_pkg::num_masters];
	logic [xbar_pkg::num_masters-1:0] r_valid_m;
	logic [xbar_pkg::num_masters-1:0] r_ready_m;
	xbar_pkg::ars_t ar_s [xbar_pkg::num_slaves];
	logic [xbar_pkg::num_slaves-1:0] ar_valid_s;
	logic [xbar_pkg::num_slaves-1:0] ar_ready_s;
	xbar_pkg::rs_t r_s [xbar_pkg::num_slaves];
	logic [xbar_pkg::num_slaves-1:0] r_valid_s;
	logic [xbar_pkg::num_slaves-1:0] r_ready_s;
	logic [xbar_pkg::num_slaves-1:0] accept;

	// Scoreboard state
	int next_row [xbar_pkg::num_masters];
	int cur_row [xbar_pkg::num_masters];
	logic [xbar_pkg::num_masters-1:0] ar_fire;
	logic in_flight [num_rows];
	logic ar_seen [num_rows];
	int beats_seen [num_rows];
	int done_count;
	int cycles;

	xbar i_xbar (
		.clk(clk),
		.rst_n(rst_n),
		.ar_m(ar_m),
		.ar_valid_m(ar_valid_m),
		.ar_ready_m(ar_ready_m),
		.r_m(r_m),
		.r_valid_m(r_valid_m),
		.r_ready_m(r_ready_m),
		.ar_s(ar_s),
		.ar_valid_s(ar_valid_s),
		.ar_ready_s(ar_ready_s),
		.r_s(r_s),
		.r_valid_s(r_valid_s),
		.r_ready_s(r_ready_s)
	);

	for (genvar s = 0; s < xbar_pkg::num_slaves; s++) begin : g_slave
		xbar_slave_model i_slave_model (
			.clk(clk),
			.rst_n(rst_n),
			.ar(ar_s[s]),
			.ar_valid(ar_valid_s[s]),
			.ar_ready(ar_ready_s[s]),
			.accept(accept[s]),
			.r(r_s[s]),
			.r_valid(r_valid_s[s]),
			.r_ready(r_ready_s[s])
		);
	end

	bind xbar xbar_chk i_xbar_chk (
		.clk(clk),
		.rst_n(rst_n),
		.ar_s(ar_s),
		.ar_valid_s(ar_valid_s),
		.ar_ready_s(ar_ready_s),
		.r_m(r_m),
		.r_valid_m(r_valid_m),
		.r_ready_m(r_ready_m),
		.req_grant(req_grant)
	);

	always #4 clk = ~clk;

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_r(input string name, input xbar_pkg::r_t got, input xbar_pkg::r_t exp);
		if (got !== exp)
			fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_ar(input string name, input xbar_pkg::ars_t got,
			input xbar_pkg::ars_t exp);
		if (got !== exp)
			fail_run($sformatf("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	task automatic check_slave(input string name, input logic [xbar_pkg::slave_idx_w-1:0] got,
			input logic [xbar_pkg::slave_idx_w-1:0] exp);
		if (got !== exp)
			fail_run($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	function automatic int row_after(input int m, input int from);
		for (int i = from; i < num_rows; i++)
			if (int'(stim[i].master) == m)
				return i;
		return num_rows;
	endfunction

	// In-flight row of a master with this ID whose request has or has not gone out
	function automatic int find_row(input int m, input logic [xbar_pkg::id_w-1:0] id,
			input logic seen);
		for (int i = 0; i < num_rows; i++)
			if (in_flight[i] && ar_seen[i] == seen && int'(stim[i].master) == m
					&& stim[i].id == id)
				return i;
		return -1;
	endfunction

	function automatic xbar_pkg::ar_t request_for(input int row);
		xbar_pkg::ar_t a;
		a.id = stim[row].id;
		a.addr = stim[row].addr;
		a.len = stim[row].len;
		a.size = beat_size;
		a.burst = burst_incr;
		return a;
	endfunction

	// Master index sits above the original ID
	function automatic xbar_pkg::ars_t expected_ar(input int row);
		xbar_pkg::ars_t a;
		a.id = {stim[row].master, stim[row].id};
		a.addr = stim[row].addr;
		a.len = stim[row].len;
		a.size = beat_size;
		a.burst = burst_incr;
		return a;
	endfunction

	// Beat k carries the inverted address of that beat
	function automatic xbar_pkg::r_t expected_beat(input int row, input int k);
		xbar_pkg::r_t b;
		b.id = stim[row].id;
		b.data = ~(stim[row].addr + xbar_pkg::addr_w'(4 * k));
		b.resp = xbar_pkg::resp_okay;
		b.last = (k == int'(stim[row].len));
		return b;
	endfunction

	task automatic draw_ready();
		for (int m = 0; m < xbar_pkg::num_masters; m++)
			r_ready_m[m] = ($urandom % 4) != 0;
		for (int s = 0; s < xbar_pkg::num_slaves; s++)
			accept[s] = ($urandom % 4) != 0;
	endtask

	task automatic drive_requests();
		for (int m = 0; m < xbar_pkg::num_masters; m++) begin
			if (ar_fire[m])
				next_row[m] = row_after(m, next_row[m] + 1);
			if (next_row[m] < num_rows) begin
				ar_m[m] = request_for(next_row[m]);
				ar_valid_m[m] = 1'b1;
			end else
				ar_valid_m[m] = 1'b0;
			// Handshake completes at the coming rising edge
			ar_fire[m] = ar_valid_m[m] && ar_ready_m[m];
			if (ar_fire[m])
				in_flight[next_row[m]] = 1'b1;
		end
	endtask

	task automatic watch_requests();
		int m;
		int row;
		for (int s = 0; s < xbar_pkg::num_slaves; s++) begin
			if (ar_valid_s[s] && accept[s]) begin
				m = int'(ar_s[s].id[xbar_pkg::ids_w-1 -: xbar_pkg::master_idx_w]);
				row = find_row(m, ar_s[s].id[xbar_pkg::id_w-1:0], 1'b0);
				if (row < 0)
					fail_run($sformatf("ar_s[%0d] carried ID %h, which no master has pending",
						s, ar_s[s].id));
				else begin
					check_slave($sformatf("slave of ID %h", ar_s[s].id),
						xbar_pkg::slave_idx_w'(s), stim[row].slave);
					check_ar($sformatf("ar_s[%0d]", s), ar_s[s], expected_ar(row));
					ar_seen[row] = 1'b1;
				end
			end
		end
	endtask

	task automatic watch_returns();
		int row;
		for (int m = 0; m < xbar_pkg::num_masters; m++) begin
			if (r_valid_m[m] && r_ready_m[m]) begin
				row = find_row(m, r_m[m].id, 1'b1);
				if (row < 0)
					fail_run($sformatf("Beat with ID %h reached master %0d, which has no such read",
						r_m[m].id, m));
				else if (cur_row[m] >= 0 && row != cur_row[m])
					fail_run($sformatf("Burst of ID %h on master %0d was cut by ID %h",
						stim[cur_row[m]].id, m, r_m[m].id));
				else begin
					check_r($sformatf("r_m[%0d]", m), r_m[m], expected_beat(row, beats_seen[row]));
					beats_seen[row]++;
					if (r_m[m].last) begin
						in_flight[row] = 1'b0;
						done_count++;
						cur_row[m] = -1;
					end else
						cur_row[m] = row;
				end
			end
		end
	endtask

	initial begin
		void'($urandom(32'h826e));
		clk = 1'b0;
		rst_n = 1'b0;
		ar_valid_m = '0;
		r_ready_m = '0;
		accept = '0;
		ar_fire = '0;
		done_count = 0;
		cycles = 0;
		for (int m = 0; m < xbar_pkg::num_masters; m++) begin
			ar_m[m] = '0;
			next_row[m] = row_after(m, 0);
			cur_row[m] = -1;
		end
		for (int i = 0; i < num_rows; i++) begin
			in_flight[i] = 1'b0;
			ar_seen[i] = 1'b0;
			beats_seen[i] = 0;
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		while (done_count < num_rows) begin
			@(negedge clk);
			cycles++;
			if (cycles > timeout_cycles)
				fail_run($sformatf("Timeout after %0d cycles, %0d of %0d reads complete",
					cycles, done_count, num_rows));
			else begin
				draw_ready();
				drive_requests();
				watch_requests();
				watch_returns();
			end
		end
		// Fabric goes quiet with every queue empty once all reads are done
		repeat (4) @(negedge clk);
		if (r_valid_m == '0 && ar_valid_s == '0 && r_valid_s == '0 && ar_ready_m == '1
				&& r_ready_s == '1) begin
			$display("Testbench passed");
			$finish;
		end else
			fail_run("Fabric was not idle with empty queues after every read had completed");
	end

endmodule
